// File: src.f
+incdir+include
rtl/ooo_pkg.sv
rtl/instr_decoder.sv
rtl/rename_unit.sv
rtl/phys_reg_file.sv
rtl/reservation_station.sv
rtl/int_alu.sv
rtl/multiplier.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verification/ooo_core_tb.sv

// File: verification/ooo_core_tb.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    // funct7 and funct3 of the R-type ops
    localparam logic [9:0] F_ADD = 10'b0000000_000;
    localparam logic [9:0] F_SUB = 10'b0100000_000;
    localparam logic [9:0] F_AND = 10'b0000000_111;
    localparam logic [9:0] F_OR  = 10'b0000000_110;
    localparam logic [9:0] F_XOR = 10'b0000000_100;
    localparam logic [9:0] F_SLT = 10'b0000000_010;
    localparam logic [9:0] F_MUL = 10'b0000001_000;

    localparam int NUM_INSTR      = 62;  // words sent by all tests
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (`MUL_LATENCY + `ROB_DEPTH) + 16 + 300;

    logic             clk;
    logic             reset;
    logic             instr_valid;
    logic [`XLEN-1:0] instr;
    logic             dispatch_stall;
    commit_t          commit;

    logic [`XLEN-1:0] ref_regs [32];
    commit_t          exp_q [$];
    string            name_q [$];
    string            test_name;
    integer           seed;
    int               errors;
    int               checks;
    logic             stall_seen;

    ooo_core ooo_core_inst (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .dispatch_stall(dispatch_stall),
        .commit(commit)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] r_word(input logic [9:0] f, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // expected result straight from the ISA definition
    function automatic logic [`XLEN-1:0] rtype_result(input logic [9:0] f,
                                                      input logic [`XLEN-1:0] a,
                                                      input logic [`XLEN-1:0] b);
        case (f)
            F_ADD:   return a + b;
            F_SUB:   return a - b;
            F_AND:   return a & b;
            F_OR:    return a | b;
            F_XOR:   return a ^ b;
            F_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F_MUL:   return a * b;  // low word
            default: return '0;
        endcase
    endfunction

    task automatic dispatch_word(input logic [31:0] word);
        while (dispatch_stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr       = word;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic expect_commit(input logic [4:0] rd, input logic [`XLEN-1:0] value);
        exp_q.push_back('{valid: 1'b1, write: (rd != 5'd0), rd: rd, value: value});
        name_q.push_back(test_name);
        if (rd != 5'd0)
            ref_regs[rd] = value;
    endtask

    task automatic send_addi(input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        logic [`XLEN-1:0] res;
        res = ref_regs[rs1] + {{(`XLEN-12){imm[11]}}, imm};
        expect_commit(rd, res);
        dispatch_word(i_word(rd, rs1, imm));
    endtask

    task automatic send_rtype(input logic [9:0] f, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [`XLEN-1:0] res;
        res = rtype_result(f, ref_regs[rs1], ref_regs[rs2]);
        expect_commit(rd, res);
        dispatch_word(r_word(f, rd, rs1, rs2));
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic check_commit();
        commit_t exp;
        string   name;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("unexpected commit to x%0d while nothing was pending", commit.rd);
        end
        if (exp_q.size() != 0) begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            checks++;
            assert (commit.rd == exp.rd) else begin
                errors++;
                $display("CHECK FAILED %s rd: expected %0d, actual %0d", name, exp.rd, commit.rd);
            end
            assert (commit.write == exp.write) else begin
                errors++;
                $display("CHECK FAILED %s write: expected %0b, actual %0b",
                         name, exp.write, commit.write);
            end
            if (exp.write) begin
                assert (commit.value == exp.value) else begin
                    errors++;
                    $display("CHECK FAILED %s x%0d: expected %h, actual %h",
                             name, exp.rd, exp.value, commit.value);
                end
            end
        end
    endtask

    // commit changes only on the rising edge
    always @(negedge clk) begin
        if (!reset && commit.valid)
            check_commit();
    end

    task automatic test_reset_idle();
        test_name = "reset_idle";
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (!commit.valid && !dispatch_stall) else begin
                errors++;
                $display("CHECK FAILED %s valid/stall: expected 00, actual %0b%0b",
                         test_name, commit.valid, dispatch_stall);
            end
        end
    endtask

    task automatic test_alu_chain();
        test_name = "alu_chain";
        send_addi(5'd1, 5'd0, 12'($random(seed)));
        send_addi(5'd2, 5'd0, 12'($random(seed)));
        send_addi(5'd3, 5'd1, 12'($random(seed)));
        send_rtype(F_ADD, 5'd4, 5'd1, 5'd2);
        send_rtype(F_SUB, 5'd5, 5'd4, 5'd3);
        send_rtype(F_AND, 5'd6, 5'd5, 5'd2);
        send_rtype(F_OR,  5'd7, 5'd6, 5'd3);
        send_rtype(F_XOR, 5'd8, 5'd7, 5'd1);
        send_rtype(F_SLT, 5'd9, 5'd1, 5'd2);
        send_rtype(F_SLT, 5'd10, 5'd2, 5'd1);
        send_addi(5'd11, 5'd10, 12'hfff);
        drain();
    endtask

    task automatic test_mul_order();
        test_name = "mul_order";
        send_rtype(F_MUL, 5'd12, 5'd1, 5'd2);
        send_rtype(F_ADD, 5'd13, 5'd3, 5'd4);  // finishes first yet commits second
        drain();
    endtask

    task automatic test_mul_chain();
        test_name = "mul_chain";
        send_rtype(F_MUL, 5'd14, 5'd1, 5'd2);
        send_rtype(F_ADD, 5'd15, 5'd14, 5'd3);
        send_rtype(F_MUL, 5'd16, 5'd15, 5'd15);
        drain();
    endtask

    task automatic test_burst();
        logic [4:0] rd;
        logic [4:0] prev;
        test_name  = "burst";
        stall_seen = 1'b0;
        prev       = 5'd1;
        for (int i = 0; i < 40; i++) begin
            rd = 5'(1 + ({$random(seed)} % 31));
            if (i % 3 == 0)
                send_addi(rd, prev, 12'($random(seed)));
            else
                send_rtype(F_MUL, rd, prev, 5'($random(seed)));
            prev = rd;  // every op reads the one before it
        end
        drain();
        assert (stall_seen) else begin
            errors++;
            $display("dispatch_stall never rose during the burst");
        end
    endtask

    task automatic test_x0();
        test_name = "x0_and_illegal";
        send_addi(5'd0, 5'd1, 12'h005);
        send_rtype(F_ADD, 5'd0, 5'd2, 5'd3);
        dispatch_word(32'h0000_0003);  // load opcode is not decoded
        dispatch_word(r_word(10'b0100000_111, 5'd20, 5'd1, 5'd2));
        send_rtype(F_ADD, 5'd17, 5'd0, 5'd0);
        send_addi(5'd18, 5'd0, 12'h007);
        drain();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'h4171;
        errors      = 0;
        checks      = 0;
        stall_seen  = 1'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        test_reset_idle();
        test_alu_chain();
        test_mul_order();
        test_mul_chain();
        test_burst();
        test_x0();
        $display("checks %0d, errors %0d, pending %0d", checks, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // bounds the run even if a commit never arrives
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        errors++;
        $display("timeout after %0d cycles with %0d expected commits never drained",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("checks %0d, errors %0d, pending %0d", checks, errors, exp_q.size());
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: rtl/ooo_core.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module ooo_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  logic [`XLEN-1:0]   instr,
    output logic               dispatch_stall,
    output ooo_pkg::commit_t   commit
);
    import ooo_pkg::*;

    uop_t                  uop;
    src_t                  src1;
    src_t                  src2;
    src_t                  op_b;
    cdb_t                  cdb [2];
    alu_payload_t          alu_payload;
    alu_payload_t          alu_issue_payload;
    mul_payload_t          mul_payload;
    mul_payload_t          mul_issue_payload;
    logic [`PTAG_W-1:0]    src1_tag;
    logic [`PTAG_W-1:0]    src2_tag;
    logic [`PTAG_W-1:0]    dest_tag;
    logic [`PTAG_W-1:0]    old_tag;
    logic [`PTAG_W-1:0]    commit_tag;
    logic [`ROB_IDX_W-1:0] rob_idx;
    logic [`ROB_IDX_W-1:0] alu_issue_rob;
    logic [`ROB_IDX_W-1:0] mul_issue_rob;
    logic [`XLEN-1:0]      alu_a;
    logic [`XLEN-1:0]      alu_b;
    logic [`XLEN-1:0]      mul_a;
    logic [`XLEN-1:0]      mul_b;
    logic                  free_empty;
    logic                  rob_full;
    logic                  alu_full;
    logic                  mul_full;
    logic                  alu_issue;
    logic                  mul_issue;
    logic                  commit_free;
    logic                  fire;

    // stall is a pure function of state
    assign dispatch_stall = free_empty | rob_full | alu_full | mul_full;
    assign fire = instr_valid & ~dispatch_stall & uop.legal;

    // addi takes the immediate as an always-ready operand
    assign op_b = uop.use_imm ? '{ready: 1'b1, tag: '0, value: uop.imm} : src2;
    assign alu_payload = '{op: uop.op, dest: dest_tag};
    assign mul_payload = '{dest: dest_tag};

    instr_decoder decoder (
        .instr(instr),
        .uop(uop)
    );

    rename_unit rename (
        .clk(clk),
        .reset(reset),
        .dispatch(fire),
        .uop(uop),
        .src1_tag(src1_tag),
        .src2_tag(src2_tag),
        .dest_tag(dest_tag),
        .old_tag(old_tag),
        .free_empty(free_empty),
        .commit_free(commit_free),
        .commit_tag(commit_tag)
    );

    phys_reg_file prf (
        .clk(clk),
        .reset(reset),
        .src1_tag(src1_tag),
        .src2_tag(src2_tag),
        .alloc(fire & uop.has_dest),
        .alloc_tag(dest_tag),
        .src1(src1),
        .src2(src2),
        .cdb(cdb)
    );

    reservation_station #(.payload_t(alu_payload_t)) alu_rs (
        .clk(clk),
        .reset(reset),
        .write(fire & ~uop.is_mul),
        .write_payload(alu_payload),
        .write_rob(rob_idx),
        .write_src1(src1),
        .write_src2(op_b),
        .full(alu_full),
        .cdb(cdb),
        .issue(alu_issue),
        .issue_payload(alu_issue_payload),
        .issue_rob(alu_issue_rob),
        .issue_a(alu_a),
        .issue_b(alu_b)
    );

    reservation_station #(.payload_t(mul_payload_t)) mul_rs (
        .clk(clk),
        .reset(reset),
        .write(fire & uop.is_mul),
        .write_payload(mul_payload),
        .write_rob(rob_idx),
        .write_src1(src1),
        .write_src2(src2),
        .full(mul_full),
        .cdb(cdb),
        .issue(mul_issue),
        .issue_payload(mul_issue_payload),
        .issue_rob(mul_issue_rob),
        .issue_a(mul_a),
        .issue_b(mul_b)
    );

    int_alu alu (
        .clk(clk),
        .reset(reset),
        .issue(alu_issue),
        .payload(alu_issue_payload),
        .rob(alu_issue_rob),
        .a(alu_a),
        .b(alu_b),
        .result(cdb[0])
    );

    multiplier mul (
        .clk(clk),
        .reset(reset),
        .issue(mul_issue),
        .payload(mul_issue_payload),
        .rob(mul_issue_rob),
        .a(mul_a),
        .b(mul_b),
        .result(cdb[1])
    );

    reorder_buffer rob (
        .clk(clk),
        .reset(reset),
        .dispatch(fire),
        .uop(uop),
        .dest_tag(dest_tag),
        .old_tag(old_tag),
        .alloc_idx(rob_idx),
        .full(rob_full),
        .cdb(cdb),
        .commit(commit),
        .commit_free(commit_free),
        .commit_tag(commit_tag)
    );

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch,
    input  ooo_pkg::uop_t         uop,
    input  logic [`PTAG_W-1:0]    dest_tag,
    input  logic [`PTAG_W-1:0]    old_tag,
    output logic [`ROB_IDX_W-1:0] alloc_idx,
    output logic                  full,
    input  ooo_pkg::cdb_t         cdb [2],
    output ooo_pkg::commit_t      commit,
    output logic                  commit_free,
    output logic [`PTAG_W-1:0]    commit_tag
);
    localparam int CNT_W  = `ROB_IDX_W + 1;
    localparam int AREG_W = $clog2(`ARCH_REGS);

    logic [`ROB_IDX_W-1:0] head;
    logic [`ROB_IDX_W-1:0] tail;
    logic [CNT_W-1:0]      count;
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] has_dest;
    logic [AREG_W-1:0]     arch_rd [`ROB_DEPTH];
    logic [`PTAG_W-1:0]    new_tag [`ROB_DEPTH];
    logic [`PTAG_W-1:0]    prev_tag [`ROB_DEPTH];
    logic [`XLEN-1:0]      value [`ROB_DEPTH];

    assign alloc_idx = tail;
    assign full      = (count == CNT_W'(`ROB_DEPTH));

    // retire the head as soon as its result is in
    assign commit.valid = busy[head] & done[head];
    assign commit.write = has_dest[head];
    assign commit.rd    = arch_rd[head];
    assign commit.value = value[head];
    assign commit_free  = commit.valid & has_dest[head];
    assign commit_tag   = prev_tag[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            done  <= '0;
        end else begin
            if (dispatch) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            for (int b = 0; b < 2; b++) begin
                if (cdb[b].valid)
                    done[cdb[b].rob] <= 1'b1;
            end
            if (commit.valid) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + CNT_W'(dispatch) - CNT_W'(commit.valid);
        end
        if (dispatch) begin
            has_dest[tail] <= uop.has_dest;
            arch_rd[tail]  <= uop.rd;
            new_tag[tail]  <= dest_tag;
            prev_tag[tail] <= old_tag;
        end
        for (int b = 0; b < 2; b++) begin
            if (cdb[b].valid)
                value[cdb[b].rob] <= cdb[b].value;
        end
    end

    assert property (@(posedge clk) disable iff (reset) dispatch |-> !full);

    // a result must land on a live slot, once, under the tag renamed at dispatch
    for (genvar b = 0; b < 2; b++) begin : g_bus_check
        assert property (@(posedge clk) disable iff (reset)
            cdb[b].valid |-> busy[cdb[b].rob] && !done[cdb[b].rob]
                && (!has_dest[cdb[b].rob] || new_tag[cdb[b].rob] == cdb[b].tag));
    end

endmodule

// File: rtl/multiplier.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module multiplier (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  ooo_pkg::mul_payload_t payload,
    input  logic [`ROB_IDX_W-1:0] rob,
    input  logic [`XLEN-1:0]      a,
    input  logic [`XLEN-1:0]      b,
    output ooo_pkg::cdb_t         result
);
    import ooo_pkg::*;

    // each stage carries its own tag and rob slot
    cdb_t             stage [`MUL_LATENCY];
    logic [`XLEN-1:0] product;

    assign product = a * b;  // low word only
    assign result  = stage[`MUL_LATENCY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MUL_LATENCY; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else begin
            stage[0] <= '{valid: issue, tag: payload.dest, rob: rob, value: product};
            for (int i = 1; i < `MUL_LATENCY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module int_alu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  ooo_pkg::alu_payload_t payload,
    input  logic [`ROB_IDX_W-1:0] rob,
    input  logic [`XLEN-1:0]      a,
    input  logic [`XLEN-1:0]      b,
    output ooo_pkg::cdb_t         result
);
    import ooo_pkg::*;

    logic [`XLEN-1:0] alu_out;

    always_comb begin
        case (payload.op)
            ALU_SUB: alu_out = a - b;
            ALU_AND: alu_out = a & b;
            ALU_OR:  alu_out = a | b;
            ALU_XOR: alu_out = a ^ b;
            ALU_SLT: alu_out = `XLEN'($signed(a) < $signed(b));
            default: alu_out = a + b;
        endcase
    end

    // drives bus 0 one cycle after issue
    always_ff @(posedge clk) begin
        if (reset)
            result.valid <= 1'b0;
        else
            result <= '{valid: issue, tag: payload.dest, rob: rob, value: alu_out};
    end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module reservation_station #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write,
    input  payload_t              write_payload,
    input  logic [`ROB_IDX_W-1:0] write_rob,
    input  ooo_pkg::src_t         write_src1,
    input  ooo_pkg::src_t         write_src2,
    output logic                  full,
    input  ooo_pkg::cdb_t         cdb [2],
    output logic                  issue,
    output payload_t              issue_payload,
    output logic [`ROB_IDX_W-1:0] issue_rob,
    output logic [`XLEN-1:0]      issue_a,
    output logic [`XLEN-1:0]      issue_b
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    typedef struct packed {
        logic                  valid;
        payload_t              payload;
        logic [`ROB_IDX_W-1:0] rob;
        src_t                  s1;
        src_t                  s2;
    } entry_t;

    // slot 0 is the oldest and entries stay packed toward it
    entry_t            ent [`RS_DEPTH];
    entry_t            nxt [`RS_DEPTH];
    logic [IDX_W-1:0]  sel;

    assign full          = ent[`RS_DEPTH-1].valid;
    assign issue_payload = ent[sel].payload;
    assign issue_rob     = ent[sel].rob;
    assign issue_a       = ent[sel].s1.value;
    assign issue_b       = ent[sel].s2.value;

    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin  // lowest ready slot wins
            if (ent[i].valid && ent[i].s1.ready && ent[i].s2.ready) begin
                issue = 1'b1;
                sel   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        logic placed;
        placed = 1'b0;
        nxt    = ent;
        // wakeup
        for (int i = 0; i < `RS_DEPTH; i++) begin
            for (int b = 0; b < 2; b++) begin
                if (cdb[b].valid && !nxt[i].s1.ready && nxt[i].s1.tag == cdb[b].tag) begin
                    nxt[i].s1.ready = 1'b1;
                    nxt[i].s1.value = cdb[b].value;
                end
                if (cdb[b].valid && !nxt[i].s2.ready && nxt[i].s2.tag == cdb[b].tag) begin
                    nxt[i].s2.ready = 1'b1;
                    nxt[i].s2.value = cdb[b].value;
                end
            end
        end
        if (issue) begin  // collapse over the issued slot
            for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                if (IDX_W'(i) >= sel)
                    nxt[i] = nxt[i+1];
            end
            nxt[`RS_DEPTH-1].valid = 1'b0;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (write && !placed && !nxt[i].valid) begin
                nxt[i] = '{valid: 1'b1, payload: write_payload, rob: write_rob,
                           s1: write_src1, s2: write_src2};
                placed = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                ent[i].valid <= 1'b0;
            end
        end else begin
            ent <= nxt;
        end
    end

    // core must hold dispatch while this station reports full
    assert property (@(posedge clk) disable iff (reset) write |-> !full);

endmodule

// File: rtl/phys_reg_file.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module phys_reg_file (
    input  logic               clk,
    input  logic               reset,
    input  logic [`PTAG_W-1:0] src1_tag,
    input  logic [`PTAG_W-1:0] src2_tag,
    input  logic               alloc,
    input  logic [`PTAG_W-1:0] alloc_tag,
    output ooo_pkg::src_t      src1,
    output ooo_pkg::src_t      src2,
    input  ooo_pkg::cdb_t      cdb [2]
);
    import ooo_pkg::*;

    logic [`XLEN-1:0]      regs [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] ready;

    function automatic src_t read_tag(input logic [`PTAG_W-1:0] tag);
        src_t s;
        s.ready = ready[tag];
        s.tag   = tag;
        s.value = regs[tag];
        // bypass a result landing this cycle
        for (int b = 0; b < 2; b++) begin
            if (cdb[b].valid && cdb[b].tag == tag && tag != '0) begin
                s.ready = 1'b1;
                s.value = cdb[b].value;
            end
        end
        return s;
    endfunction

    always_comb begin
        src1 = read_tag(src1_tag);
        src2 = read_tag(src2_tag);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= {{(`PHYS_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alloc)
                ready[alloc_tag] <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                if (cdb[b].valid && cdb[b].tag != '0) begin  // p0 stays zero
                    regs[cdb[b].tag]  <= cdb[b].value;
                    ready[cdb[b].tag] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/rename_unit.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module rename_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               dispatch,
    input  ooo_pkg::uop_t      uop,
    output logic [`PTAG_W-1:0] src1_tag,
    output logic [`PTAG_W-1:0] src2_tag,
    output logic [`PTAG_W-1:0] dest_tag,
    output logic [`PTAG_W-1:0] old_tag,
    output logic               free_empty,
    input  logic               commit_free,
    input  logic [`PTAG_W-1:0] commit_tag
);
    // at most PHYS_REGS - ARCH_REGS tags can be free at once
    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    localparam int CNT_W    = FL_PTR_W + 1;

    logic [`PTAG_W-1:0] rat [`ARCH_REGS];
    logic [`PTAG_W-1:0] free_list [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [CNT_W-1:0]    fl_count;
    logic                pop;

    assign pop        = dispatch & uop.has_dest;
    assign free_empty = (fl_count == '0);
    assign src1_tag   = rat[uop.rs1];
    assign src2_tag   = rat[uop.rs2];
    assign old_tag    = rat[uop.rd];
    assign dest_tag   = uop.has_dest ? free_list[fl_head] : '0;  // p0 means no write

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= `PTAG_W'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= `PTAG_W'(`ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= CNT_W'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat[uop.rd] <= free_list[fl_head];
                fl_head     <= fl_head + 1'b1;
            end
            if (commit_free) begin
                free_list[fl_tail] <= commit_tag;  // recycled old mapping
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + CNT_W'(commit_free) - CNT_W'(pop);
        end
    end

    // the ROB only frees tags that an earlier dispatch popped
    assert property (@(posedge clk) disable iff (reset)
        commit_free |-> fl_count < CNT_W'(FL_DEPTH));

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/100ps
`include "ooo_params.svh"

module instr_decoder (
    input  logic [`XLEN-1:0] instr,
    output ooo_pkg::uop_t    uop
);
    import ooo_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        uop.rd       = instr[11:7];
        uop.has_dest = (instr[11:7] != 5'd0);  // x0 is never written
        uop.rs1      = instr[19:15];
        uop.rs2      = instr[24:20];
        uop.imm      = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        uop.use_imm  = 1'b0;
        uop.op       = ALU_ADD;
        uop.is_mul   = 1'b0;
        uop.legal    = 1'b0;
        case (opcode)
            7'b0010011: begin  // op-imm accepts addi only
                uop.use_imm = 1'b1;
                uop.legal   = (funct3 == 3'b000);
            end
            7'b0110011: begin
                uop.legal = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: uop.op = ALU_ADD;
                    10'b0100000_000: uop.op = ALU_SUB;
                    10'b0000000_111: uop.op = ALU_AND;
                    10'b0000000_110: uop.op = ALU_OR;
                    10'b0000000_100: uop.op = ALU_XOR;
                    10'b0000000_010: uop.op = ALU_SLT;
                    10'b0000001_000: uop.is_mul = 1'b1;  // low half of product
                    default:         uop.legal = 1'b0;
                endcase
            end
            default: uop.legal = 1'b0;
        endcase
    end

endmodule

// File: rtl/ooo_pkg.sv
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef struct packed {
        logic                  has_dest;  // low for rd == x0
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic                  use_imm;
        logic [`XLEN-1:0]      imm;
        alu_op_t               op;
        logic                  is_mul;
        logic                  legal;
    } uop_t;

    typedef struct packed {
        logic                  ready;
        logic [`PTAG_W-1:0]    tag;
        logic [`XLEN-1:0]      value;
    } src_t;

    typedef struct packed {
        alu_op_t               op;
        logic [`PTAG_W-1:0]    dest;
    } alu_payload_t;

    typedef struct packed {
        logic [`PTAG_W-1:0]    dest;
    } mul_payload_t;

    typedef struct packed {
        logic                  valid;
        logic [`PTAG_W-1:0]    tag;
        logic [`ROB_IDX_W-1:0] rob;
        logic [`XLEN-1:0]      value;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [4:0]            rd;
        logic [`XLEN-1:0]      value;
    } commit_t;

endpackage

// File: include/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath
`define XLEN 32

// register files
`define ARCH_REGS 32
`define PHYS_REGS 64
`define PTAG_W 6

// window sizes
`define ROB_DEPTH 16
`define ROB_IDX_W 4
`define RS_DEPTH 4

// multiplier pipeline stages
`define MUL_LATENCY 3

`endif
